// File: src/icache_pkg.sv
package icache_pkg;

    // address geometry
    localparam int addr_w = 32;
    localparam int index_w = 6;
    localparam int num_lines = 1 << index_w;
    localparam int offset_w = 2;
    localparam int tag_w = addr_w - index_w - offset_w;

    // credits held after reset
    localparam int mem_credits = 2;
    localparam int fetch_credits = 2;
    localparam int mem_credit_w = $clog2(mem_credits + 1);
    localparam int fetch_credit_w = $clog2(fetch_credits + 1);

    localparam logic [addr_w-1:0] reset_pc = 32'h0000_0100;

    // controller states
    localparam int ctrl_state_w = 3;
    localparam logic [ctrl_state_w-1:0] st_idle = 3'd0;
    localparam logic [ctrl_state_w-1:0] st_compare = 3'd1;
    localparam logic [ctrl_state_w-1:0] st_refill_req = 3'd2;
    localparam logic [ctrl_state_w-1:0] st_refill_wait = 3'd3;
    localparam logic [ctrl_state_w-1:0] st_replay = 3'd4;

    // fetch address, as a plain word or split for the cache
    typedef union packed {
        logic [addr_w-1:0] raw;
        struct packed {
            logic [tag_w-1:0] tag;
            logic [index_w-1:0] index;
            logic [offset_w-1:0] offset;
        } fields;
    } icache_addr_u;

endpackage

// File: src/icache_tag_array.sv
`timescale 1ns/100ps

module icache_tag_array (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [icache_pkg::index_w-1:0] rd_index,
    input  logic                         wr_en,
    input  logic [icache_pkg::index_w-1:0] wr_index,
    input  logic [icache_pkg::tag_w-1:0]   wr_tag,
    input  logic [31:0]                  wr_data,
    output logic                         rd_valid,
    output logic [icache_pkg::tag_w-1:0]   rd_tag,
    output logic [31:0]                  rd_data
);

    import icache_pkg::*;

    logic [num_lines-1:0] valid_q;
    logic [tag_w-1:0] tag_mem [num_lines];
    logic [31:0] data_mem [num_lines];
    logic fwd;

    // same-index write during a read
    assign fwd = wr_en && (wr_index == rd_index);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_q <= '0;
        end
        else if (wr_en)
        begin
            valid_q[wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            tag_mem[wr_index] <= wr_tag;
            data_mem[wr_index] <= wr_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rd_valid <= 1'b0;
        end
        else
        begin
            rd_valid <= fwd ? 1'b1 : valid_q[rd_index];
        end
    end

    // forward the refill so a replay sees the new line
    always_ff @(posedge clk)
    begin
        if (fwd)
        begin
            rd_tag <= wr_tag;
            rd_data <= wr_data;
        end
        else
        begin
            rd_tag <= tag_mem[rd_index];
            rd_data <= data_mem[rd_index];
        end
    end

endmodule

// File: src/icache_controller.sv
`timescale 1ns/100ps

module icache_controller (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           lookup_valid,
    input  icache_pkg::icache_addr_u       lookup_addr,
    output logic                           lookup_ready,
    output logic                           hit_valid,
    output logic [31:0]                    hit_data,
    output logic [icache_pkg::index_w-1:0] rd_index,
    input  logic                           rd_valid,
    input  logic [icache_pkg::tag_w-1:0]   rd_tag,
    input  logic [31:0]                    rd_data,
    output logic                           wr_en,
    output logic [icache_pkg::index_w-1:0] wr_index,
    output logic [icache_pkg::tag_w-1:0]   wr_tag,
    output logic [31:0]                    wr_data,
    output logic                           mem_req_valid,
    output logic [icache_pkg::addr_w-1:0]  mem_req_addr,
    input  logic                           mem_rsp_valid,
    input  logic [31:0]                    mem_rsp_data,
    input  logic                           mem_credit_return
);

    import icache_pkg::*;

    logic [ctrl_state_w-1:0] state;
    logic [ctrl_state_w-1:0] state_next;
    icache_addr_u addr_q;
    logic [mem_credit_w-1:0] credit_cnt;
    logic hit;

    assign lookup_ready = (state == st_idle);

    // idle reads the incoming index, all other states the held one
    assign rd_index = (state == st_idle) ? lookup_addr.fields.index : addr_q.fields.index;

    assign hit = rd_valid && (rd_tag == addr_q.fields.tag);

    assign mem_req_valid = (state == st_refill_req) && (credit_cnt != '0);
    assign mem_req_addr = {addr_q.fields.tag, addr_q.fields.index, {offset_w{1'b0}}};

    // refill writes the word as it arrives
    assign wr_en = (state == st_refill_wait) && mem_rsp_valid;
    assign wr_index = addr_q.fields.index;
    assign wr_tag = addr_q.fields.tag;
    assign wr_data = mem_rsp_data;

    always_comb
    begin
        state_next = state;
        case (state)
            st_idle:
            begin
                if (lookup_valid)
                begin
                    state_next = st_compare;
                end
            end
            st_compare:
            begin
                state_next = hit ? st_idle : st_refill_req;
            end
            st_refill_req:
            begin
                if (mem_req_valid)
                begin
                    state_next = st_refill_wait;
                end
            end
            st_refill_wait:
            begin
                if (mem_rsp_valid)
                begin
                    state_next = st_replay;
                end
            end
            st_replay:
            begin
                state_next = st_compare;
            end
            default:
            begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= st_idle;
        end
        else
        begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk)
    begin
        if (lookup_valid && lookup_ready)
        begin
            addr_q <= lookup_addr;
        end
        hit_data <= rd_data;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            hit_valid <= 1'b0;
        end
        else
        begin
            hit_valid <= (state == st_compare) && hit;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            credit_cnt <= mem_credit_w'(mem_credits);
        end
        else
        begin
            credit_cnt <= credit_cnt - mem_credit_w'(mem_req_valid)
                        + mem_credit_w'(mem_credit_return);
        end
    end

    a_req_needs_credit: assert property (@(posedge clk) disable iff (rst)
        $rose(mem_req_valid) |-> $past(credit_cnt) != '0 || $past(mem_credit_return));

    a_credit_bound: assert property (@(posedge clk) disable iff (rst)
        credit_cnt <= mem_credits);

    a_hit_after_compare: assert property (@(posedge clk) disable iff (rst)
        hit_valid |-> $past(state == st_compare));

endmodule

// File: src/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          redirect_valid,
    input  logic [icache_pkg::addr_w-1:0] redirect_pc,
    output logic                          lookup_valid,
    output icache_pkg::icache_addr_u      lookup_addr,
    input  logic                          lookup_ready,
    input  logic                          hit_valid,
    input  logic [31:0]                   hit_data,
    output logic                          instr_valid,
    output logic [icache_pkg::addr_w-1:0] instr_pc,
    output logic [31:0]                   instr_data,
    input  logic                          fetch_credit_return
);

    import icache_pkg::*;

    logic [addr_w-1:0] pc_q;
    icache_addr_u open_pc_q;
    icache_addr_u issue_addr;
    logic open_q;
    logic stale_q;
    logic [fetch_credit_w-1:0] credit_cnt;
    logic issue;
    logic deliver;
    logic squash;

    // one lookup at a time, and only with a credit for its answer
    assign issue = !open_q && (credit_cnt != '0) && !redirect_valid;
    assign deliver = hit_valid && !stale_q && !redirect_valid;
    assign squash = hit_valid && !deliver;

    assign lookup_addr = open_pc_q;

    always_comb
    begin
        issue_addr.raw = pc_q;
        issue_addr.fields.offset = '0;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc_q <= reset_pc;
            open_q <= 1'b0;
            stale_q <= 1'b0;
            lookup_valid <= 1'b0;
            instr_valid <= 1'b0;
        end
        else
        begin
            if (redirect_valid)
            begin
                pc_q <= redirect_pc;
            end
            else if (deliver)
            begin
                pc_q <= pc_q + addr_w'(4);
            end

            if (issue)
            begin
                open_q <= 1'b1;
                stale_q <= 1'b0;
                lookup_valid <= 1'b1;
            end
            else
            begin
                if (lookup_valid && lookup_ready)
                begin
                    lookup_valid <= 1'b0;
                end
                if (hit_valid)
                begin
                    open_q <= 1'b0;
                end
                else if (redirect_valid && open_q)
                begin
                    stale_q <= 1'b1;
                end
            end

            instr_valid <= deliver;
        end
    end

    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            open_pc_q <= issue_addr;
        end
        if (deliver)
        begin
            instr_pc <= open_pc_q.raw;
            instr_data <= hit_data;
        end
    end

    // reserve on issue, hand back on squash
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            credit_cnt <= fetch_credit_w'(fetch_credits);
        end
        else
        begin
            credit_cnt <= credit_cnt - fetch_credit_w'(issue)
                        + fetch_credit_w'(fetch_credit_return)
                        + fetch_credit_w'(squash);
        end
    end

    a_instr_reserved: assert property (@(posedge clk) disable iff (rst)
        instr_valid |-> $past(open_q && hit_valid));

    a_single_lookup: assert property (@(posedge clk) disable iff (rst)
        (lookup_valid && lookup_ready) |=> !lookup_valid until_with hit_valid);

endmodule

// File: src/icache_fetch_top.sv
`timescale 1ns/100ps

module icache_fetch_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          redirect_valid,
    input  logic [icache_pkg::addr_w-1:0] redirect_pc,
    output logic                          instr_valid,
    output logic [icache_pkg::addr_w-1:0] instr_pc,
    output logic [31:0]                   instr_data,
    input  logic                          fetch_credit_return,
    output logic                          mem_req_valid,
    output logic [icache_pkg::addr_w-1:0] mem_req_addr,
    input  logic                          mem_rsp_valid,
    input  logic [31:0]                   mem_rsp_data,
    input  logic                          mem_credit_return
);

    import icache_pkg::*;

    // fetch to cache
    logic lookup_valid;
    logic lookup_ready;
    icache_addr_u lookup_addr;
    logic hit_valid;
    logic [31:0] hit_data;

    // cache to array
    logic [index_w-1:0] rd_index;
    logic rd_valid;
    logic [tag_w-1:0] rd_tag;
    logic [31:0] rd_data;
    logic wr_en;
    logic [index_w-1:0] wr_index;
    logic [tag_w-1:0] wr_tag;
    logic [31:0] wr_data;

    fetch_unit u_fetch_unit (
        .clk                (clk),
        .rst                (rst),
        .redirect_valid     (redirect_valid),
        .redirect_pc        (redirect_pc),
        .lookup_valid       (lookup_valid),
        .lookup_addr        (lookup_addr),
        .lookup_ready       (lookup_ready),
        .hit_valid          (hit_valid),
        .hit_data           (hit_data),
        .instr_valid        (instr_valid),
        .instr_pc           (instr_pc),
        .instr_data         (instr_data),
        .fetch_credit_return(fetch_credit_return)
    );

    icache_controller u_icache_controller (
        .clk              (clk),
        .rst              (rst),
        .lookup_valid     (lookup_valid),
        .lookup_addr      (lookup_addr),
        .lookup_ready     (lookup_ready),
        .hit_valid        (hit_valid),
        .hit_data         (hit_data),
        .rd_index         (rd_index),
        .rd_valid         (rd_valid),
        .rd_tag           (rd_tag),
        .rd_data          (rd_data),
        .wr_en            (wr_en),
        .wr_index         (wr_index),
        .wr_tag           (wr_tag),
        .wr_data          (wr_data),
        .mem_req_valid    (mem_req_valid),
        .mem_req_addr     (mem_req_addr),
        .mem_rsp_valid    (mem_rsp_valid),
        .mem_rsp_data     (mem_rsp_data),
        .mem_credit_return(mem_credit_return)
    );

    icache_tag_array u_icache_tag_array (
        .clk     (clk),
        .rst     (rst),
        .rd_index(rd_index),
        .wr_en   (wr_en),
        .wr_index(wr_index),
        .wr_tag  (wr_tag),
        .wr_data (wr_data),
        .rd_valid(rd_valid),
        .rd_tag  (rd_tag),
        .rd_data (rd_data)
    );

endmodule

// File: testbench/tb_icache_fetch.sv
`timescale 1ns/100ps

module tb_icache_fetch;

    import icache_pkg::*;

    localparam int num_rows = 6;
    localparam logic [31:0] data_mask = 32'hA5A5_0000;

    logic clk;
    logic rst;
    logic redirect_valid;
    logic [addr_w-1:0] redirect_pc;
    logic instr_valid;
    logic [addr_w-1:0] instr_pc;
    logic [31:0] instr_data;
    logic fetch_credit_return;
    logic mem_req_valid;
    logic [addr_w-1:0] mem_req_addr;
    logic mem_rsp_valid;
    logic [31:0] mem_rsp_data;
    logic mem_credit_return;

    // stimulus table
    logic row_redirect [num_rows];
    logic row_at_miss [num_rows];
    logic [addr_w-1:0] row_pc [num_rows];
    int row_count [num_rows];
    int row_hold [num_rows];
    int row_reqs [num_rows];

    // memory model state
    logic [addr_w-1:0] req_addr_q[$];
    int credit_due_q[$];
    int rsp_due;
    int req_cnt;
    int credit_ret_cnt;

    // decode model state
    logic [addr_w-1:0] got_pc_q[$];
    logic [31:0] got_data_q[$];
    int owed;
    int hold_left;
    int held_cnt;

    int cycle_cnt;
    int cycle_limit;
    int checks_run;
    int checks_failed;
    logic [addr_w-1:0] next_pc;

    icache_fetch_top u_icache_fetch_top (
        .clk                (clk),
        .rst                (rst),
        .redirect_valid     (redirect_valid),
        .redirect_pc        (redirect_pc),
        .instr_valid        (instr_valid),
        .instr_pc           (instr_pc),
        .instr_data         (instr_data),
        .fetch_credit_return(fetch_credit_return),
        .mem_req_valid      (mem_req_valid),
        .mem_req_addr       (mem_req_addr),
        .mem_rsp_valid      (mem_rsp_valid),
        .mem_rsp_data       (mem_rsp_data),
        .mem_credit_return  (mem_credit_return)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #4 clk = ~clk;
        end
    end

    // end the run if the rows stall
    initial
    begin
        wait (cycle_limit > 0 && cycle_cnt > cycle_limit);
        $display("timeout: no result after %0d cycles", cycle_limit);
        $display("test failed");
        $finish;
    end

    task automatic set_row(input int r, input logic redir, input logic at_miss,
                           input logic [addr_w-1:0] pc, input int count, input int hold,
                           input int reqs);
        row_redirect[r] = redir;
        row_at_miss[r] = at_miss;
        row_pc[r] = pc;
        row_count[r] = count;
        row_hold[r] = hold;
        row_reqs[r] = reqs;
    endtask

    task automatic load_table();
        // redirect, at miss, target pc, instructions, hold cycles, memory requests
        set_row(0, 1'b0, 1'b0, reset_pc, 8, 0, 8);
        set_row(1, 1'b1, 1'b0, reset_pc, 8, 0, 0);
        // same index as reset_pc, other tag
        set_row(2, 1'b1, 1'b0, reset_pc + 256, 8, 0, 8);
        set_row(3, 1'b1, 1'b0, reset_pc, 8, 0, 8);
        set_row(4, 1'b0, 1'b0, '0, 6, 40, 6);
        // old miss plus four new words
        set_row(5, 1'b1, 1'b1, reset_pc + 512, 4, 0, 5);
    endtask

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks_run++;
        assert (got === exp)
        else
        begin
            checks_failed++;
            $display("mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic require(input logic cond, input string what);
        checks_run++;
        assert (cond === 1'b1)
        else
        begin
            checks_failed++;
            $display("error at %0t: %s", $time, what);
        end
    endtask

    // one clock of the memory and decode models
    task automatic advance_cycle();
        @(posedge clk);
        #1;
        cycle_cnt++;
        redirect_valid = 1'b0;
        fetch_credit_return = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_credit_return = 1'b0;

        if (rsp_due == cycle_cnt)
        begin
            mem_rsp_valid = 1'b1;
            mem_rsp_data = req_addr_q.pop_front() ^ data_mask;
            credit_due_q.push_back(cycle_cnt + 1 + int'($urandom % 3));
            rsp_due = -1;
        end
        if (mem_req_valid)
        begin
            require(req_cnt < credit_ret_cnt + mem_credits,
                    "memory request sent with no memory credit left");
            // the word still owed to decode is the one being missed
            compare_word("mem_req_addr", mem_req_addr, next_pc);
            req_cnt++;
            req_addr_q.push_back(mem_req_addr);
        end
        if (rsp_due < 0 && req_addr_q.size() > 0)
        begin
            rsp_due = cycle_cnt + 1 + int'($urandom % 6);
        end
        // at most one credit pulse per cycle
        if (credit_due_q.size() > 0 && credit_due_q[0] <= cycle_cnt)
        begin
            credit_due_q.delete(0);
            mem_credit_return = 1'b1;
            credit_ret_cnt++;
        end

        if (instr_valid)
        begin
            got_pc_q.push_back(instr_pc);
            got_data_q.push_back(instr_data);
            owed++;
            if (hold_left > 0)
            begin
                held_cnt++;
            end
        end
        if (hold_left > 0)
        begin
            hold_left--;
        end
        else if (owed > 0)
        begin
            fetch_credit_return = 1'b1;
            owed--;
        end
    endtask

    task automatic run_row(input int r);
        int start_reqs;
        int start_fails;
        int n_got;
        logic [addr_w-1:0] first_pc;
        logic [addr_w-1:0] got_pc;
        logic [31:0] got_data;
        start_reqs = req_cnt;
        start_fails = checks_failed;
        held_cnt = 0;
        // let the lookup in flight reach its refill request
        if (row_at_miss[r])
        begin
            while (mem_req_valid !== 1'b1)
            begin
                advance_cycle();
            end
        end
        if (row_redirect[r])
        begin
            redirect_valid = 1'b1;
            redirect_pc = row_pc[r];
            next_pc = row_pc[r];
        end
        first_pc = next_pc;
        hold_left = row_hold[r];
        n_got = 0;
        while (n_got < row_count[r])
        begin
            advance_cycle();
            while (got_pc_q.size() > 0 && n_got < row_count[r])
            begin
                got_pc = got_pc_q.pop_front();
                got_data = got_data_q.pop_front();
                compare_word("instr_pc", got_pc, next_pc);
                compare_word("instr_data", got_data, next_pc ^ data_mask);
                next_pc = next_pc + 4;
                n_got++;
            end
        end
        compare_word("memory request count", req_cnt - start_reqs, row_reqs[r]);
        if (row_hold[r] > 0)
        begin
            require(held_cnt <= fetch_credits,
                    "more instructions arrived than decode credits while credits were held");
        end
        $display("row %0d done: %0d instructions from 0x%0h, %0d memory requests, %0d errors",
                 r, n_got, first_pc, req_cnt - start_reqs, checks_failed - start_fails);
    endtask

    initial
    begin
        int total;
        rst = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc = '0;
        fetch_credit_return = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data = '0;
        mem_credit_return = 1'b0;
        rsp_due = -1;
        req_cnt = 0;
        credit_ret_cnt = 0;
        owed = 0;
        hold_left = 0;
        held_cnt = 0;
        cycle_cnt = 0;
        checks_run = 0;
        checks_failed = 0;
        next_pc = reset_pc;
        void'($urandom(92));

        load_table();
        total = 0;
        for (int r = 0; r < num_rows; r++)
        begin
            total += row_count[r];
        end
        cycle_limit = total * 20 + 200;

        repeat (2)
        begin
            advance_cycle();
        end
        rst = 1'b0;
        require(mem_req_valid === 1'b0, "mem_req_valid is high after reset");
        require(instr_valid === 1'b0, "instr_valid is high after reset");

        for (int r = 0; r < num_rows; r++)
        begin
            run_row(r);
        end

        $display("%0d checks, %0d failed, %0d cycles", checks_run, checks_failed, cycle_cnt);
        if (checks_failed == 0)
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: icache_fetch.f
src/icache_pkg.sv
src/icache_tag_array.sv
src/icache_controller.sv
src/fetch_unit.sv
src/icache_fetch_top.sv
testbench/tb_icache_fetch.sv

// File: Bender.yml
package:
  name: icache_fetch

dependencies: {}

sources:
  # package first, then the RTL bottom up
  - files:
      - src/icache_pkg.sv
      - src/icache_tag_array.sv
      - src/icache_controller.sv
      - src/fetch_unit.sv
      - src/icache_fetch_top.sv

  # testbench, top module tb_icache_fetch
  - target: test
    files:
      - testbench/tb_icache_fetch.sv
